//--- hw/link_test_pkg.sv
// Shared sizes, register map and config/status types for the SPI link self-test.
// The LFSR polynomial is fixed at x^15+x^14+1. Seeds are never zero once in the register block.
package link_test_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    // LFSR width, feedback enters bit 0
    localparam int prbs_width = 15;
    // Bits per compared byte
    localparam int byte_bits = 8;

    // ======================================================================
    // Register map on a 2-bit address
    // ======================================================================
    localparam logic [1:0] addr_ctrl  = 2'd0;
    localparam logic [1:0] addr_seed  = 2'd1;
    localparam logic [1:0] addr_err   = 2'd2;
    localparam logic [1:0] addr_bytes = 2'd3;

    // Configuration seen by the engine, generator and checker
    typedef struct packed {
        logic                  enable;
        logic                  external_loop;
        logic [prbs_width-1:0] seed;
    } link_cfg_t;

    // Counters returned from the checker to the registers
    typedef struct packed {
        logic [7:0]  error_count;
        logic [15:0] byte_count;
    } link_status_t;

endpackage

//--- hw/link_test_regs.sv
// Register block for the link self-test. Writes take effect on the wr_en edge, reads are
// combinational. A zero seed is stored as 1 so the LFSR never locks up.
module link_test_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en,
    input  logic [1:0]                 addr,
    input  logic [15:0]                wdata,
    output logic [15:0]                rdata,
    input  link_test_pkg::link_status_t status,
    output link_test_pkg::link_cfg_t    cfg,
    output logic                       clear_count
);

    logic wr_ctrl;
    logic wr_seed;
    logic [link_test_pkg::prbs_width-1:0] seed_in;

    assign wr_ctrl = wr_en && (addr == link_test_pkg::addr_ctrl);
    assign wr_seed = wr_en && (addr == link_test_pkg::addr_seed);

    // Substitute 1 for an all-zero seed
    assign seed_in = (wdata[link_test_pkg::prbs_width-1:0] == '0) ?
                     link_test_pkg::prbs_width'(1) : wdata[link_test_pkg::prbs_width-1:0];

    // ======================================================================
    // Configuration and clear pulse
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.enable        <= 1'b0;
            cfg.external_loop <= 1'b0;
            cfg.seed          <= link_test_pkg::prbs_width'(1);
            clear_count       <= 1'b0;
        end else begin
            // Bit 2 of a control write is a command, not stored
            clear_count <= wr_ctrl && wdata[2];
            if (wr_ctrl) begin
                cfg.enable        <= wdata[0];
                cfg.external_loop <= wdata[1];
            end
            if (wr_seed) begin
                cfg.seed <= seed_in;
            end
        end
    end

    // ======================================================================
    // Read mux
    // ======================================================================
    always_comb begin
        case (addr)
            link_test_pkg::addr_ctrl:  rdata = {14'd0, cfg.external_loop, cfg.enable};
            link_test_pkg::addr_seed:  rdata = {1'b0, cfg.seed};
            link_test_pkg::addr_err:   rdata = {8'd0, status.error_count};
            link_test_pkg::addr_bytes: rdata = status.byte_count;
            default:                   rdata = '0;
        endcase
    end

endmodule

//--- hw/prbs_gen.sv
// Fibonacci LFSR, x^15+x^14+1, with the feedback shifted into bit 0.
// The seed must be non-zero, the register block guarantees this.
module prbs_gen (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  logic                                 shift,
    input  logic [link_test_pkg::prbs_width-1:0] seed,
    output logic                                 tx_bit
);

    logic [link_test_pkg::prbs_width-1:0] lfsr;
    logic                                 feedback;

    // Taps at x^15 and x^14
    assign feedback = lfsr[link_test_pkg::prbs_width-1] ^ lfsr[link_test_pkg::prbs_width-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= link_test_pkg::prbs_width'(1);
        end else if (start) begin
            lfsr <= seed;
        end else if (shift) begin
            lfsr <= {lfsr[link_test_pkg::prbs_width-2:0], feedback};
        end
    end

    // Top bit is the next bit to go out
    assign tx_bit = lfsr[link_test_pkg::prbs_width-1];

endmodule

//--- hw/spi_bit_engine.sv
// SPI master timing for the self-test: sclk runs at clk/2 while cs_n is low, mode 0 style.
// mosi moves only on falling sclk, the receive bit is taken on rising sclk.
module spi_bit_engine (
    input  logic                      clk,
    input  logic                      rst,
    input  link_test_pkg::link_cfg_t cfg,
    input  logic                      tx_bit,
    input  logic                      miso,
    output logic                      sclk,
    output logic                      cs_n,
    output logic                      mosi,
    output logic                      start,
    output logic                      shift,
    output logic                      sample,
    output logic                      rx_bit
);

    logic rise;
    logic fall;

    // First cycle of a session, cs_n still high
    assign start = cfg.enable & cs_n;

    // sclk goes high at the end of a low phase and low at the end of a high phase
    assign rise = cfg.enable & ~cs_n & ~sclk;
    assign fall = cfg.enable & ~cs_n & sclk;

    // Step the LFSR in each low phase so tx_bit already holds the next bit at the fall
    assign shift = rise;

    // ======================================================================
    // Select and clock
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_n   <= 1'b1;
            sclk   <= 1'b0;
            sample <= 1'b0;
        end else begin
            cs_n   <= ~cfg.enable;
            sclk   <= rise;
            sample <= rise;
        end
    end

    // ======================================================================
    // Data pins
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mosi   <= 1'b0;
            rx_bit <= 1'b0;
        end else begin
            // Bit 0 of the sequence is the seed's top bit, the LFSR loads in this cycle
            if (!cfg.enable) begin
                mosi <= 1'b0;
            end else if (start) begin
                mosi <= cfg.seed[link_test_pkg::prbs_width-1];
            end else if (fall) begin
                mosi <= tx_bit;
            end
            // internal loopback reads back our own mosi
            if (rise) begin
                rx_bit <= cfg.external_loop ? miso : mosi;
            end
        end
    end

endmodule

//--- hw/loop_checker.sv
// Byte compare and counters. A byte ends on its 8th sample; bytes cut short by cs_n are lost.
// error_count saturates at 255, byte_count wraps.
module loop_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sample,
    input  logic                          cs_n,
    input  logic                          mosi,
    input  logic                          rx_bit,
    input  logic                          clear_count,
    output logic                          error_flag,
    output link_test_pkg::link_status_t   status
);

    logic [$clog2(link_test_pkg::byte_bits)-1:0] bit_cnt;
    logic [link_test_pkg::byte_bits-1:0]         tx_byte;
    logic [link_test_pkg::byte_bits-1:0]         rx_byte;
    logic                                        byte_done;
    logic                                        byte_bad;

    assign byte_done = sample && (int'(bit_cnt) == link_test_pkg::byte_bits - 1);
    // Include the bit arriving with this sample
    assign byte_bad  = {tx_byte[link_test_pkg::byte_bits-2:0], mosi} !=
                       {rx_byte[link_test_pkg::byte_bits-2:0], rx_bit};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt    <= '0;
            tx_byte    <= '0;
            rx_byte    <= '0;
            error_flag <= 1'b0;
            status     <= '0;
        end else begin
            error_flag <= byte_done && byte_bad;
            if (cs_n) begin
                bit_cnt <= '0;
            end else if (sample) begin
                bit_cnt <= bit_cnt + 1'b1;
                tx_byte <= {tx_byte[link_test_pkg::byte_bits-2:0], mosi};
                rx_byte <= {rx_byte[link_test_pkg::byte_bits-2:0], rx_bit};
            end
            // Clear wins over a byte ending in the same cycle
            if (clear_count) begin
                status <= '0;
            end else if (byte_done) begin
                status.byte_count <= status.byte_count + 1'b1;
                if (byte_bad && (status.error_count != 8'hff)) begin
                    status.error_count <= status.error_count + 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/spi_link_test.sv
// SPI link self-test top. mosi and miso are plain one-way pins, the external loop
// is closed outside this block.
module spi_link_test (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic [1:0]  addr,
    input  logic [15:0] wdata,
    output logic [15:0] rdata,
    output logic        sclk,
    output logic        cs_n,
    output logic        mosi,
    input  logic        miso,
    output logic        error_flag,
    output logic [7:0]  error_count
);

    link_test_pkg::link_cfg_t    cfg;
    link_test_pkg::link_status_t status;
    logic                        clear_count;
    logic                        start;
    logic                        shift;
    logic                        sample;
    logic                        rx_bit;
    logic                        tx_bit;

    // ======================================================================
    // Configuration
    // ======================================================================
    link_test_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .status      (status),
        .cfg         (cfg),
        .clear_count (clear_count)
    );

    // ======================================================================
    // Bit stream and SPI timing
    // ======================================================================
    prbs_gen u_prbs (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .shift  (shift),
        .seed   (cfg.seed),
        .tx_bit (tx_bit)
    );

    spi_bit_engine u_engine (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .tx_bit (tx_bit),
        .miso   (miso),
        .sclk   (sclk),
        .cs_n   (cs_n),
        .mosi   (mosi),
        .start  (start),
        .shift  (shift),
        .sample (sample),
        .rx_bit (rx_bit)
    );

    // Compare and count
    loop_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .sample      (sample),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .rx_bit      (rx_bit),
        .clear_count (clear_count),
        .error_flag  (error_flag),
        .status      (status)
    );

    assign error_count = status.error_count;

endmodule

//--- tests/spi_link_test_assert.sv
// Protocol and counter assertions, bound into the self-test top level.
module spi_link_test_assert (
    input logic       clk,
    input logic       rst,
    input logic       sclk,
    input logic       cs_n,
    input logic       mosi,
    input logic       error_flag,
    input logic       clear_count,
    input logic [7:0] error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    a_mosi_low: assert property (@(posedge clk) disable iff (rst) $changed(mosi) |-> !sclk)
        else begin
            failures++;
            $error("mosi changed while sclk was high");
        end
    a_sclk_idle: assert property (@(posedge clk) disable iff (rst) cs_n |-> !sclk)
        else begin
            failures++;
            $error("sclk high while cs_n was high");
        end
    a_flag_pulse: assert property (@(posedge clk) disable iff (rst) error_flag |=> !error_flag)
        else begin
            failures++;
            $error("error_flag held for more than one cycle");
        end
    a_count_up: assert property (@(posedge clk) disable iff (rst)
        (error_count < $past(error_count)) |-> $past(clear_count))
        else begin
            failures++;
            $error("error_count fell without a clear");
        end

endmodule

bind spi_link_test spi_link_test_assert u_assert (
    .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
    .error_flag(error_flag), .clear_count(clear_count), .error_count(error_count)
);

//--- tests/link_monitor.sv
// Checking module for the SPI link self-test. It samples the pins on rising sclk.
// The seed and loop mode come from the testbench, and a zero seed counts as seed 1.
module link_monitor (
    input logic        clk,
    input logic        rst,
    input logic        sclk,
    input logic        cs_n,
    input logic        mosi,
    input logic        miso,
    input logic        error_flag,
    input logic [7:0]  error_count,
    input logic        ext_loop,
    input logic [14:0] seed
);
    timeunit 1ns;
    timeprecision 1ps;

    int         bit_idx = 0;
    int         bit_in_byte = 0;
    int         bytes_seen = 0;
    int         bad_bytes = 0;
    int         flag_pulses = 0;
    int         bit_errors = 0;
    logic       rx_now;
    logic [7:0] tx_byte = '0;
    logic [7:0] rx_byte = '0;

    // Baselines taken at the start of each test
    int base_bytes = 0;
    int base_bad = 0;
    int base_flags = 0;
    int base_bit_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int mismatches = 0;

    // ======================================================================
    // Reference model
    // ======================================================================
    // Bit number index of the sequence sent from a seed
    function automatic logic prbs_bit(input logic [14:0] start_seed, input int index);
        logic [14:0] state;
        state = (start_seed == '0) ? 15'd1 : start_seed;
        for (int i = 0; i < index; i++) begin
            state = {state[13:0], state[14] ^ state[13]};
        end
        return state[14];
    endfunction

    // Bytes with a flip, as the DUT counter shows them
    function automatic int expected_errors(input int bad);
        return (bad > 255) ? 255 : bad;
    endfunction

    // ======================================================================
    // Pin sampling
    // ======================================================================
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            // End of session drops the partial byte and restarts the sequence
            bit_idx = 0;
            bit_in_byte = 0;
        end else begin
            rx_now = ext_loop ? miso : mosi;
            if (mosi !== prbs_bit(seed, bit_idx)) begin
                $display("Mismatch at %0t: mosi bit %0d is %b, expected %b",
                         $time, bit_idx, mosi, prbs_bit(seed, bit_idx));
                bit_errors++;
            end
            tx_byte = {tx_byte[6:0], mosi};
            rx_byte = {rx_byte[6:0], rx_now};
            bit_idx++;
            bit_in_byte++;
            if (bit_in_byte == link_test_pkg::byte_bits) begin
                bit_in_byte = 0;
                bytes_seen++;
                if (tx_byte != rx_byte) begin
                    bad_bytes++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && error_flag) begin
            flag_pulses++;
        end
    end

    function automatic int bytes_in_test();
        return bytes_seen - base_bytes;
    endfunction

    task automatic reset_counts();
        base_bytes = bytes_seen;
        base_bad = bad_bytes;
        base_flags = flag_pulses;
        base_bit_errors = bit_errors;
    endtask

    // ======================================================================
    // Per-test compare and report
    // ======================================================================
    task automatic close_test(input string name, input logic [15:0] err_reg,
                              input logic [15:0] bytes_reg, input bit check_pins);
        int fails;
        int bad;
        int exp_err;
        fails = bit_errors - base_bit_errors;
        bad = bad_bytes - base_bad;
        exp_err = expected_errors(bad);
        if (check_pins && (cs_n !== 1'b1 || sclk !== 1'b0 || error_flag !== 1'b0)) begin
            $display("Mismatch at %0t: pins not idle, cs_n %b sclk %b error_flag %b",
                     $time, cs_n, sclk, error_flag);
            fails++;
        end
        if (int'(err_reg) != exp_err) begin
            $display("Mismatch at %0t: error_count %0d, expected %0d", $time, err_reg, exp_err);
            fails++;
        end
        if (int'(error_count) != exp_err) begin
            $display("Mismatch at %0t: error_count pin %0d, expected %0d",
                     $time, error_count, exp_err);
            fails++;
        end
        if (bytes_reg != 16'(bytes_seen - base_bytes)) begin
            $display("Mismatch at %0t: byte_count %0d, expected %0d",
                     $time, bytes_reg, bytes_seen - base_bytes);
            fails++;
        end
        if ((flag_pulses - base_flags) != bad) begin
            $display("Mismatch at %0t: %0d error_flag pulses, expected %0d",
                     $time, flag_pulses - base_flags, bad);
            fails++;
        end
        tests_run++;
        mismatches += fails;
        if (fails != 0) begin
            tests_failed++;
            $display("test %s: FAIL with %0d mismatches", name, fails);
        end else begin
            $display("test %s: ok, %0d bytes, %0d bad", name, bytes_seen - base_bytes, bad);
        end
    endtask

    task automatic print_summary();
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
                 mismatches);
    endtask

endmodule

//--- tests/tb_spi_link_test.sv
// Testbench for the SPI link self-test. miso is mosi XOR an inject bit, so the
// external loop is closed here. Counters are read back through the register port.
module tb_spi_link_test;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rst;
    logic        wr_en;
    logic [1:0]  addr;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic        sclk;
    logic        cs_n;
    logic        mosi;
    logic        miso;
    logic        error_flag;
    logic [7:0]  error_count;
    logic        inject = 1'b0;
    logic        ext_loop;
    logic [14:0] seed_value;
    logic [15:0] err_reg;
    logic [15:0] bytes_reg;
    int          inject_mode;
    int          watchdog_cycles;
    integer      rand_seed = 32'hb4c0;

    assign miso = mosi ^ inject;

    spi_link_test dut (
        .clk(clk), .rst(rst), .wr_en(wr_en), .addr(addr), .wdata(wdata), .rdata(rdata),
        .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso), .error_flag(error_flag),
        .error_count(error_count)
    );

    link_monitor mon (
        .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso),
        .error_flag(error_flag), .error_count(error_count), .ext_loop(ext_loop),
        .seed(seed_value)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Mode 0 none, 1 sparse flips, 2 every bit, 3 random garbage
    always @(posedge clk) begin
        #2;
        case (inject_mode)
            0: inject = 1'b0;
            1: inject = (($random(rand_seed) & 15) == 0);
            2: inject = 1'b1;
            default: inject = (($random(rand_seed) & 1) != 0);
        endcase
    end

    task automatic write_reg(input logic [1:0] a, input logic [15:0] d);
        @(posedge clk);
        #2;
        wr_en = 1'b1;
        addr = a;
        wdata = d;
        @(posedge clk);
        #2;
        wr_en = 1'b0;
    endtask

    task automatic read_counts();
        @(posedge clk);
        #2 addr = link_test_pkg::addr_err;
        @(posedge clk);
        #1 err_reg = rdata;
        #1 addr = link_test_pkg::addr_bytes;
        @(posedge clk);
        #1 bytes_reg = rdata;
    endtask

    task automatic stop_link();
        write_reg(link_test_pkg::addr_ctrl, 16'h0);
        repeat (4) @(posedge clk);
    endtask

    // Stop, clear the counters, program the seed and enable
    task automatic start_link(input logic [14:0] s, input logic ext, input int mode);
        stop_link();
        write_reg(link_test_pkg::addr_ctrl, 16'h4);
        mon.reset_counts();
        seed_value = s;
        ext_loop = ext;
        inject_mode = mode;
        write_reg(link_test_pkg::addr_seed, {1'b0, s});
        write_reg(link_test_pkg::addr_ctrl, ext ? 16'h3 : 16'h1);
    endtask

    task automatic wait_bytes(input int n);
        while (mon.bytes_in_test() < n) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        stop_link();
        read_counts();
        mon.close_test(name, err_reg, bytes_reg, 1'b0);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        wr_en = 1'b0;
        addr = 2'd0;
        wdata = 16'h0;
        inject_mode = 0;
        ext_loop = 1'b0;
        seed_value = 15'd1;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;

        read_counts();
        mon.close_test("reset", err_reg, bytes_reg, 1'b1);
        start_link(15'h5a3c, 1'b0, 0);
        wait_bytes(4);
        end_test("seed");
        start_link(15'h0000, 1'b0, 0);
        wait_bytes(4);
        end_test("zero seed");
        start_link(15'h1234, 1'b0, 3);
        wait_bytes(20);
        end_test("internal loopback");
        start_link(15'h7001, 1'b1, 1);
        wait_bytes(40);
        end_test("external loop");
        start_link(15'h2b2b, 1'b1, 2);
        wait_bytes(260);
        end_test("saturation");

        inject_mode = 0;
        write_reg(link_test_pkg::addr_ctrl, 16'h4);
        mon.reset_counts();
        read_counts();
        mon.close_test("clear", err_reg, bytes_reg, 1'b0);

        // Drop enable in mid-byte, then start again from the seed
        start_link(15'h0f0f, 1'b0, 1);
        wait_bytes(2);
        repeat (5) @(posedge clk);
        write_reg(link_test_pkg::addr_ctrl, 16'h0);
        while (!cs_n) @(posedge clk);
        repeat (4) @(posedge clk);
        write_reg(link_test_pkg::addr_ctrl, 16'h1);
        wait_bytes(4);
        end_test("restart");

        mon.print_summary();
        if (mon.tests_failed == 0 && dut.u_assert.failures == 0) begin
            $display("test passed");
        end else begin
            if (dut.u_assert.failures != 0) begin
                $display("%0d assertion failures", dut.u_assert.failures);
            end
            $display("test failed");
        end
        $finish;
    end

    // Bytes of all tests at 16 cycles each, plus setup margin
    initial begin
        watchdog_cycles = (4 + 4 + 20 + 40 + 260 + 4) * 16 + 2000;
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display("test failed");
        $finish;
    end

endmodule

//--- spi_link_test.f
hw/link_test_pkg.sv
hw/link_test_regs.sv
hw/prbs_gen.sv
hw/spi_bit_engine.sv
hw/loop_checker.sv
hw/spi_link_test.sv
tests/spi_link_test_assert.sv
tests/link_monitor.sv
tests/tb_spi_link_test.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_spi_link_test \
		-f spi_link_test.f -Mdir obj_dir -o sim
	./obj_dir/sim +verilator+error+limit+100 | tee $(LOG)
	@grep -q "^test passed$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
